// ==== project.f ====
source/instrMemPkg.sv
source/bootRom.sv
source/programStore.sv
source/fetchSelect.sv
source/instrMemory.sv
sim/instrMemory_asserts.sv
sim/instrMemory_tb.sv

// ==== Makefile ====
# Verilator build for the instruction memory testbench

VERILATOR ?= verilator
TOP       ?= instrMemory_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)

SOURCES := $(shell cat $(FILELIST))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# exit status of the simulator is the test result
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)

// ==== sim/instrMemory_tb.sv ====
module instrMemory_tb
	import instrMemPkg::*;
();

	localparam int TIMEOUT_CYCLES = 4000; // worst case run is close to 2900 cycles
	localparam int RESET_CYCLES = 2;
	localparam int BOOT_READS = 71; // pc 0..70, runs past the rom depth
	localparam int SEQ_WORDS = 200;
	localparam int BLOCK_RUNS = 6;
	localparam int MAX_RUN = 40;

	logic              clock;
	logic              reset;
	logic [ADDR_W-1:0] pc;
	logic              encerrarBios;
	loadPort_t         load;
	decodedInstr_t     fields;
	logic              biosEmExecucao;

	instrWord_t  bootImage [DEF_BOOT_DEPTH]; // expected rom contents
	instrWord_t  progModel [int unsigned];   // words accepted by the loader
	int unsigned cursorModel;                // next write address
	int unsigned baseModel;                  // base of the open block
	bit          flagModel;                  // expected boot flag
	int          cycleCount = 0;

	instrMemory u_instrMemory (
		.clock          (clock),
		.reset          (reset),
		.pc             (pc),
		.encerrarBios   (encerrarBios),
		.load           (load),
		.fields         (fields),
		.biosEmExecucao (biosEmExecucao)
	);

	always #5 clock = ~clock; // 10 unit period

	// run limit
	always @(posedge clock) begin
		cycleCount = cycleCount + 1;
		if (cycleCount > TIMEOUT_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("CHECKS FAILED");
			$fatal(1, "run stopped by the cycle limit");
		end
	end

	// boot program, word by word
	function automatic instrWord_t bootRule(input int unsigned addr);
		instrWord_t w;
		w = '0; // unused words read zero
		if (addr == 0) begin
			w.opcode = cproc;
		end else if (addr <= 32) begin
			w.opcode = movi;
			w.rd     = 5'(addr - 1); // clears r(addr-1)
			if (addr == 31) begin
				w.imm = 11'(DEF_BLOCK_SIZE); // first block base
			end else if (addr == 32) begin
				w.imm = 11'd1800; // loop limit
			end
		end else if (addr == 33) begin
			w.opcode = sw;
			w.rs     = 5'd30;
			w.rt     = 5'd30;
			w.imm    = 11'd1; // marker at base + 1
		end else if (addr == 34) begin
			w.opcode = addi;
			w.rd     = 5'd30;
			w.rs     = 5'd30;
			w.rt     = 5'd30;
			w.imm    = 11'(DEF_BLOCK_SIZE);
		end else if (addr == 35) begin
			w.opcode = beq;
			w.rd     = 5'd31;
			w.rs     = 5'd30;
			w.rt     = 5'd31;
			w.imm    = 11'd37;
		end else if (addr == 36) begin
			w.opcode = jmp;
			w[25:0]  = 26'd33; // back to the marker store
		end else if (addr == 37) begin
			w.opcode = encBios;
		end
		return w;
	endfunction

	// split a word into the decode fields
	function automatic decodedInstr_t decodeRule(input instrWord_t w);
		decodedInstr_t d;
		logic [31:0]   raw;
		raw        = w;
		d.opcode   = opcode_t'(raw[31:26]);
		d.rd       = raw[25:21];
		d.rs       = raw[20:16];
		d.rt       = raw[15:11];
		d.imediato = raw[10:0];
		d.jump     = raw[25:0]; // overlaps rd, rs, rt and imm
		return d;
	endfunction

	// what the fetch path should show at this pc
	function automatic decodedInstr_t expectedAt(input logic [ADDR_W-1:0] addr);
		instrWord_t w;
		w = '0;
		if (flagModel) begin
			if (addr < DEF_BOOT_DEPTH) begin
				w = bootImage[addr[5:0]];
			end
		end else if (addr < DEF_PROG_DEPTH && progModel.exists(addr)) begin
			w = progModel[addr];
		end
		return decodeRule(w);
	endfunction

	function automatic instrWord_t randomWord();
		return instrWord_t'($urandom); // any opcode bits, valid or not
	endfunction

	// loader and flag rules, applied at each rising edge
	function automatic void updateModel();
		if (reset) begin
			flagModel   = 1'b1;
			cursorModel = 0;
			baseModel   = 0; // contents kept
		end else begin
			if (encerrarBios) begin
				flagModel = 1'b0;
			end
			if (load.endOfBlock) begin
				baseModel   = baseModel + DEF_BLOCK_SIZE;
				cursorModel = baseModel; // a save in this cycle is lost
			end else if (load.saveInstr) begin
				if (cursorModel < DEF_PROG_DEPTH) begin
					progModel[cursorModel] = load.data;
				end
				cursorModel = cursorModel + 1;
			end
		end
	endfunction

	task automatic stopOnFailure();
		$display("CHECKS FAILED");
		$fatal(1, "first mismatch ends the run");
	endtask

	task automatic checkFields(input string testName, input decodedInstr_t expected,
		input decodedInstr_t actual);
		if (actual !== expected) begin
			$display("Error [%s] pc %0d expected %h actual %h", testName, pc, expected, actual);
			stopOnFailure();
		end
	endtask

	task automatic checkFlag(input string testName, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("Error [%s] boot flag expected %b actual %b", testName, expected, actual);
			stopOnFailure();
		end
	endtask

	// one clock, model follows the rising edge, back on the falling edge
	task automatic tick();
		@(posedge clock);
		updateModel();
		@(negedge clock);
	endtask

	task automatic applyReset(input int cycles);
		reset = 1'b1;
		repeat (cycles) tick();
		reset = 1'b0;
	endtask

	// drive pc, let the async read settle, compare
	task automatic readCheck(input logic [ADDR_W-1:0] addr, input string testName);
		pc = addr;
		#2;
		checkFields(testName, expectedAt(addr), fields);
		tick();
	endtask

	task automatic loadWord(input instrWord_t data);
		load.saveInstr  = 1'b1;
		load.endOfBlock = 1'b0;
		load.data       = data;
		tick();
		load = '0;
	endtask

	task automatic closeBlock(input bit alsoSave);
		load.endOfBlock = 1'b1;
		load.saveInstr  = alsoSave; // must be ignored by the store
		load.data       = randomWord();
		tick();
		load = '0;
	endtask

	task automatic pulseEndOfBoot();
		encerrarBios = 1'b1;
		tick();
		encerrarBios = 1'b0;
	endtask

	initial begin
		int unsigned       runLen;
		int unsigned       waitCycles;
		logic [ADDR_W-1:0] farPc;
		instrWord_t        freshWord;

		void'($urandom(39)); // one seed for the whole run
		clock        = 1'b0;
		reset        = 1'b1;
		pc           = '0;
		encerrarBios = 1'b0;
		load         = '0;
		for (int i = 0; i < DEF_BOOT_DEPTH; i++) begin
			bootImage[i] = bootRule(i);
		end
		applyReset(RESET_CYCLES);

		// boot rom is the source after reset
		checkFlag("boot after reset", 1'b1, biosEmExecucao);
		for (int unsigned a = 0; a < BOOT_READS; a++) begin
			readCheck(a, "boot after reset");
		end

		// end of boot at a random point
		waitCycles = 1 + ($urandom % 16);
		repeat (waitCycles) begin
			tick();
			checkFlag("boot before end", 1'b1, biosEmExecucao);
		end
		pulseEndOfBoot();
		checkFlag("end of boot", 1'b0, biosEmExecucao);
		repeat (50) begin
			encerrarBios = 1'($urandom % 2); // toggling must not revive boot
			tick();
			checkFlag("flag stays low", flagModel, biosEmExecucao);
		end
		encerrarBios = 1'b0;

		// plain sequential loading into block 0
		for (int i = 0; i < SEQ_WORDS; i++) begin
			loadWord(randomWord());
		end
		for (int unsigned a = 0; a < SEQ_WORDS; a++) begin
			readCheck(a, "sequential loading");
		end

		// runs in blocks 1..6, bases 300 to 1800
		closeBlock(1'b0); // leave block 0
		for (int blk = 1; blk <= BLOCK_RUNS; blk++) begin
			runLen = 1 + ($urandom % MAX_RUN);
			repeat (runLen) loadWord(randomWord());
			closeBlock(blk % 2 == 0); // even blocks also raise save
		end
		for (int unsigned a = SEQ_WORDS; a < DEF_PROG_DEPTH; a++) begin
			readCheck(a, "block jump"); // gaps between runs read zero
		end

		// reads past the store, then writes with cursor beyond it
		repeat (30) begin
			farPc = $urandom;
			if (farPc < DEF_PROG_DEPTH) begin
				farPc = farPc + DEF_PROG_DEPTH;
			end
			readCheck(farPc, "out of range read");
		end
		repeat (20) loadWord(randomWord()); // cursor near 2100, all dropped
		for (int unsigned a = 0; a < 128; a++) begin
			readCheck(a, "dropped writes"); // would alias around index 52
		end

		// reset in the middle of the run
		applyReset(RESET_CYCLES);
		checkFlag("reset mid-run", 1'b1, biosEmExecucao);
		for (int unsigned a = 0; a <= 40; a++) begin
			readCheck(a, "reset mid-run");
		end
		freshWord = randomWord();
		if (freshWord == progModel[0]) begin
			freshWord.imm = ~freshWord.imm; // make the overwrite visible
		end
		loadWord(freshWord); // cursor back at 0
		pulseEndOfBoot();
		checkFlag("reset mid-run", 1'b0, biosEmExecucao);
		for (int unsigned a = 0; a < 3; a++) begin
			readCheck(a, "reload after reset");
		end

		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

// ==== sim/instrMemory_asserts.sv ====
module instrMemory_asserts
	import instrMemPkg::*;
(
	input logic          clock,
	input logic          reset,
	input logic          biosEmExecucao, // boot flag
	input instrWord_t    bootWord,       // rom word at pc
	input decodedInstr_t fields          // decoded output
);

	decodedInstr_t bootFields; // boot word split by hand

	assign bootFields = {
		bootWord.opcode,
		bootWord.rd,
		bootWord.rs,
		bootWord.rt,
		bootWord.imm,
		bootWord[25:0] // jump field, low 26 bits
	};

	// reset always hands the fetch path back to the rom
	flagAfterReset: assert property (@(posedge clock) reset |=> biosEmExecucao)
		else $error("boot flag not high one cycle after reset");

	// flag only rises through reset
	flagStaysLow: assert property (
		@(posedge clock) (!biosEmExecucao && !reset) |=> !biosEmExecucao
	) else $error("boot flag rose again without a reset");

	// rom decode while booting
	bootDecode: assert property (
		@(posedge clock) disable iff (reset)
		biosEmExecucao |-> (fields == bootFields)
	) else $error("fields differ from the boot word decode while booting");

endmodule

bind instrMemory instrMemory_asserts u_asserts (
	.clock          (clock),
	.reset          (reset),
	.biosEmExecucao (biosEmExecucao),
	.bootWord       (bootWord),
	.fields         (fields)
);

// ==== source/instrMemory.sv ====
module instrMemory
	import instrMemPkg::*;
#(
	parameter int BOOT_DEPTH = DEF_BOOT_DEPTH, // boot rom words
	parameter int PROG_DEPTH = DEF_PROG_DEPTH, // program store words
	parameter int BLOCK_SIZE = DEF_BLOCK_SIZE  // process block size
) (
	input  logic              clock,
	input  logic              reset,
	input  logic [ADDR_W-1:0] pc,
	input  logic              encerrarBios,
	input  loadPort_t         load,
	output decodedInstr_t     fields,
	output logic              biosEmExecucao
);

	instrWord_t bootWord; // rom word at pc
	instrWord_t progWord; // store word at pc

	bootRom #(
		.BOOT_DEPTH (BOOT_DEPTH),
		.BLOCK_SIZE (BLOCK_SIZE)
	) u_bootRom (
		.pc       (pc),
		.bootWord (bootWord)
	);

	programStore #(
		.PROG_DEPTH (PROG_DEPTH),
		.BLOCK_SIZE (BLOCK_SIZE)
	) u_programStore (
		.clock    (clock),
		.reset    (reset),
		.pc       (pc),
		.load     (load),     // loader strobes and data
		.progWord (progWord)
	);

	// flag, mux and decode
	fetchSelect u_fetchSelect (
		.clock          (clock),
		.reset          (reset),
		.encerrarBios   (encerrarBios),
		.bootWord       (bootWord),
		.progWord       (progWord),
		.fields         (fields),
		.biosEmExecucao (biosEmExecucao)
	);

endmodule

// ==== source/fetchSelect.sv ====
module fetchSelect
	import instrMemPkg::*;
(
	input  logic          clock,
	input  logic          reset,
	input  logic          encerrarBios,   // end of boot request
	input  instrWord_t    bootWord,       // word from boot rom
	input  instrWord_t    progWord,       // word from program store
	output decodedInstr_t fields,
	output logic          biosEmExecucao  // high while boot rom is the source
);

	instrWord_t selWord; // word chosen for decode

	// boot flag
	// set by reset, cleared once by the end of boot strobe
	always_ff @(posedge clock) begin
		if (reset) begin
			biosEmExecucao <= 1'b1; // boot rom first
		end else if (encerrarBios) begin
			biosEmExecucao <= 1'b0; // program store from here on
		end
	end

	// source mux, same pc for both memories
	always_comb begin
		if (biosEmExecucao) begin
			selWord = bootWord;
		end else begin
			selWord = progWord;
		end
	end

	// field split
	always_comb begin
		fields.opcode   = selWord.opcode;
		fields.rd       = selWord.rd;       // bits 25..21
		fields.rs       = selWord.rs;       // bits 20..16
		fields.rt       = selWord.rt;       // bits 15..11
		fields.imediato = selWord.imm;      // 11 bits, no padding
		fields.jump     = selWord[25:0];    // jump target overlaps reg fields
	end

endmodule

// ==== source/programStore.sv ====
module programStore
	import instrMemPkg::*;
#(
	parameter int PROG_DEPTH = DEF_PROG_DEPTH,
	parameter int BLOCK_SIZE = DEF_BLOCK_SIZE
) (
	input  logic              clock,
	input  logic              reset,
	input  logic [ADDR_W-1:0] pc,
	input  loadPort_t         load,
	output instrWord_t        progWord
);

	localparam int IDX_W = $clog2(PROG_DEPTH); // memory index width
	localparam logic [ADDR_W-1:0] STRIDE = ADDR_W'(BLOCK_SIZE); // block stride

	instrWord_t mem [PROG_DEPTH] = '{default: '0}; // powers up empty

	logic [ADDR_W-1:0] cursor;    // next word to write
	logic [ADDR_W-1:0] blockBase; // base of the block being filled
	logic [ADDR_W-1:0] nextBase;  // base after end of block
	logic              cursorIn;  // cursor inside the array
	logic              writeEn;   // accepted word write
	logic              readIn;    // pc inside the array

	assign nextBase = blockBase + STRIDE;
	assign cursorIn = cursor < PROG_DEPTH;
	assign readIn   = pc < PROG_DEPTH;

	// end of block wins over a save in the same cycle
	assign writeEn = load.saveInstr && !load.endOfBlock && cursorIn && !reset;

	// cursor and block base
	always_ff @(posedge clock) begin
		if (reset) begin
			cursor    <= '0;
			blockBase <= '0;
		end else if (load.endOfBlock) begin
			blockBase <= nextBase; // step to next process block
			cursor    <= nextBase; // restart at its base
		end else if (load.saveInstr) begin
			cursor <= cursor + ADDR_W'(1); // keeps counting past the end, writes drop
		end
	end

	// word write, no reset on contents
	always_ff @(posedge clock) begin
		if (writeEn) begin
			mem[cursor[IDX_W-1:0]] <= load.data;
		end
	end

	// async read, zero outside the array
	always_comb begin
		if (readIn) begin
			progWord = mem[pc[IDX_W-1:0]];
		end else begin
			progWord = '0;
		end
	end

endmodule

// ==== source/bootRom.sv ====
module bootRom
	import instrMemPkg::*;
#(
	parameter int BOOT_DEPTH = DEF_BOOT_DEPTH,
	parameter int BLOCK_SIZE = DEF_BLOCK_SIZE
) (
	input  logic [ADDR_W-1:0] pc,
	output instrWord_t        bootWord
);

	localparam logic [10:0] BLOCK_IMM = 11'(BLOCK_SIZE); // block stride as immediate

	logic [4:0] movRd; // target reg of the clearing movi run

	// packs one instruction word from its fields
	function automatic instrWord_t makeWord(
		input opcode_t     op,
		input regIdx_t     rd,
		input regIdx_t     rs,
		input regIdx_t     rt,
		input logic [10:0] imm
	);
		instrWord_t w;
		w.opcode = op;
		w.rd     = rd;
		w.rs     = rs;
		w.rt     = rt;
		w.imm    = imm;
		return w;
	endfunction

	assign movRd = pc[4:0] - 5'd1; // word n clears r(n-1)

	// boot program
	// clear r0..r29, load stride and limit, then mark each block base
	always_comb begin
		bootWord = '0; // empty rom word
		if (pc < BOOT_DEPTH) begin
			case (pc) inside
				32'd0: begin
					bootWord = makeWord(cproc, 5'd0, 5'd0, 5'd0, 11'd0); // switch to os process
				end
				[32'd1:32'd30]: begin
					bootWord = makeWord(movi, movRd, 5'd0, 5'd0, 11'd0); // movi rN, 0
				end
				32'd31: begin
					bootWord = makeWord(movi, 5'd30, 5'd0, 5'd0, BLOCK_IMM); // r30 = first block
				end
				32'd32: begin
					bootWord = makeWord(movi, 5'd31, 5'd0, 5'd0, 11'd1800); // r31 = loop limit
				end
				32'd33: begin
					bootWord = makeWord(sw, 5'd0, 5'd30, 5'd30, 11'd1); // sw r30, 1(r30)
				end
				32'd34: begin
					bootWord = makeWord(addi, 5'd30, 5'd30, 5'd30, BLOCK_IMM); // next block
				end
				32'd35: begin
					bootWord = makeWord(beq, 5'd31, 5'd30, 5'd31, 11'd37); // done when r30 == r31
				end
				32'd36: begin
					// jump target 33 sits entirely in the imm bits of the 26-bit field
					bootWord = makeWord(jmp, 5'd0, 5'd0, 5'd0, 11'd33);
				end
				32'd37: begin
					bootWord = makeWord(encBios, 5'd0, 5'd0, 5'd0, 11'd0); // hand over to program store
				end
				default: begin
					bootWord = '0;
				end
			endcase
		end
	end

endmodule

// ==== source/instrMemPkg.sv ====
package instrMemPkg;

	localparam int ADDR_W = 32; // pc width

	localparam int DEF_BOOT_DEPTH = 64; // boot rom words
	localparam int DEF_PROG_DEPTH = 2048; // program store words
	localparam int DEF_BLOCK_SIZE = 300; // words per process block

	typedef logic [4:0] regIdx_t; // register file index

	// instruction set, encodings kept from the processor's ISA
	typedef enum logic [5:0] {
		add     = 6'b000000,
		addi    = 6'b000001,
		sub     = 6'b000010,
		subi    = 6'b000011,
		mult    = 6'b000100,
		multi   = 6'b000101,
		div     = 6'b000110,
		divi    = 6'b000111,
		rdiv    = 6'b001000,
		jmp     = 6'b010001, // absolute jump, target in low 26 bits
		jumpR   = 6'b010010,
		jal     = 6'b010011,
		beq     = 6'b010100,
		bne     = 6'b010101,
		blt     = 6'b010110,
		lw      = 6'b010111,
		sw      = 6'b011000,
		mov     = 6'b011001,
		movi    = 6'b011010,
		mfhi    = 6'b011011,
		mflo    = 6'b011100,
		inp     = 6'b011101, // user input
		outp    = 6'b011110, // user output
		fim     = 6'b011111, // end of program
		scpc    = 6'b100001, // save pc context
		scrg    = 6'b100010, // save register context
		cproc   = 6'b100011, // change process
		encBios = 6'b100100, // end of boot
		led     = 6'b100101,
		spc     = 6'b100110
	} opcode_t;

	typedef struct packed {
		opcode_t    opcode; // bits 31..26
		regIdx_t    rd;     // bits 25..21
		regIdx_t    rs;     // bits 20..16
		regIdx_t    rt;     // bits 15..11
		logic [10:0] imm;   // bits 10..0
	} instrWord_t;

	// fields as seen by the decode stage
	typedef struct packed {
		opcode_t     opcode;
		regIdx_t     rd;
		regIdx_t     rs;
		regIdx_t     rt;
		logic [10:0] imediato; // immediate, not sign extended here
		logic [25:0] jump;     // low 26 bits of the word
	} decodedInstr_t;

	typedef struct packed {
		logic       saveInstr;  // write data at cursor
		logic       endOfBlock; // close block, jump cursor to next base
		instrWord_t data;
	} loadPort_t;

endpackage
